//--- riscv_pkg.sv
package riscv_pkg;

    // datapath sizes
    localparam int xlen = 32;
    localparam int reg_aw = 5;

    typedef logic [xlen-1:0] word_t;
    typedef logic [reg_aw-1:0] reg_addr_t;

    localparam word_t reset_pc = '0;

    // rv32i major opcodes
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_sys    = 7'b1110011;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_slt,
        alu_sltu,
        alu_pass_b
    } alu_op_t;

    typedef enum logic [2:0] {
        br_none,
        br_eq,
        br_ne,
        br_lt,
        br_ge
    } br_op_t;

    typedef enum logic [1:0] {
        mem_none,
        mem_load,
        mem_store
    } mem_op_t;

    // operand a source, then operand b source
    typedef enum logic [1:0] {
        src_rs1_rs2,
        src_rs1_imm,
        src_pc_imm,
        src_zero_imm
    } src_sel_t;

    typedef struct packed {
        word_t pc;
        word_t instr;
    } fetch_pkt_t;

    typedef struct packed {
        word_t     pc;
        word_t     imm;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        logic      rd_wen;
        alu_op_t   alu_op;
        src_sel_t  src_sel;
        br_op_t    br_op;
        mem_op_t   mem_op;
        logic      jal;
        logic      jalr;
        logic      halt;
    } dec_pkt_t;

    typedef struct packed {
        word_t     pc;
        word_t     result;
        word_t     store_data;
        word_t     next_pc;
        reg_addr_t rd;
        logic      rd_wen;
        logic      link;
        mem_op_t   mem_op;
        logic      halt;
    } exe_pkt_t;

    typedef struct packed {
        word_t paddr;
        logic  psel;
        logic  penable;
        logic  pwrite;
        word_t pwdata;
    } apb_req_t;

    typedef struct packed {
        word_t prdata;
        logic  pready;
    } apb_rsp_t;

endpackage

//--- riscv_ifu.sv
`timescale 1ns/1ps

module riscv_ifu (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  retire,
    input  riscv_pkg::word_t      next_pc,
    input  logic                  halted,
    output logic                  imem_req,
    output riscv_pkg::word_t      imem_addr,
    input  riscv_pkg::word_t      imem_data,
    output logic                  fetch_valid,
    output riscv_pkg::fetch_pkt_t fetch_pkt
);

    logic             req_q;
    riscv_pkg::word_t pc_q;

    // boot request comes out of reset, later ones follow each retire
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_q       <= 1'b1;
            pc_q        <= riscv_pkg::reset_pc;
            fetch_valid <= 1'b0;
        end else begin
            req_q       <= retire;
            fetch_valid <= imem_req;
            if (retire) begin
                pc_q <= next_pc;
            end
        end
    end

    // halted is set at the same edge as the final retire
    assign imem_req  = req_q & ~halted;
    assign imem_addr = pc_q;

    // instruction word returns one cycle after the request
    assign fetch_pkt.pc    = pc_q;
    assign fetch_pkt.instr = imem_data;

endmodule

//--- riscv_idu.sv
`timescale 1ns/1ps

module riscv_idu (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  fetch_valid,
    input  riscv_pkg::fetch_pkt_t fetch_pkt,
    output logic                  dec_valid,
    output riscv_pkg::dec_pkt_t   dec_pkt
);

    riscv_pkg::word_t    instr;
    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic                alt;
    riscv_pkg::word_t    imm_i;
    riscv_pkg::word_t    imm_s;
    riscv_pkg::word_t    imm_b;
    riscv_pkg::word_t    imm_u;
    riscv_pkg::word_t    imm_j;
    riscv_pkg::alu_op_t  func_op;
    riscv_pkg::dec_pkt_t dec_d;

    assign instr  = fetch_pkt.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    // funct7 bit 5 picks sub and sra
    assign alt    = instr[30];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // shared by op and op-imm, sub only exists for register form
    always_comb begin
        case (funct3)
            3'b000:  func_op = (alt && opcode == riscv_pkg::op_reg) ? riscv_pkg::alu_sub
                                                                     : riscv_pkg::alu_add;
            3'b001:  func_op = riscv_pkg::alu_sll;
            3'b010:  func_op = riscv_pkg::alu_slt;
            3'b011:  func_op = riscv_pkg::alu_sltu;
            3'b100:  func_op = riscv_pkg::alu_xor;
            3'b101:  func_op = alt ? riscv_pkg::alu_sra : riscv_pkg::alu_srl;
            3'b110:  func_op = riscv_pkg::alu_or;
            default: func_op = riscv_pkg::alu_and;
        endcase
    end

    always_comb begin
        // no-op unless the opcode says otherwise
        dec_d         = '0;
        dec_d.pc      = fetch_pkt.pc;
        dec_d.rs1     = instr[19:15];
        dec_d.rs2     = instr[24:20];
        dec_d.rd      = instr[11:7];
        dec_d.alu_op  = riscv_pkg::alu_pass_b;
        dec_d.src_sel = riscv_pkg::src_rs1_rs2;
        dec_d.br_op   = riscv_pkg::br_none;
        dec_d.mem_op  = riscv_pkg::mem_none;
        case (opcode)
            riscv_pkg::op_lui: begin
                dec_d.imm     = imm_u;
                dec_d.alu_op  = riscv_pkg::alu_add;
                dec_d.src_sel = riscv_pkg::src_zero_imm;
                dec_d.rd_wen  = 1'b1;
            end
            riscv_pkg::op_auipc: begin
                dec_d.imm     = imm_u;
                dec_d.alu_op  = riscv_pkg::alu_add;
                dec_d.src_sel = riscv_pkg::src_pc_imm;
                dec_d.rd_wen  = 1'b1;
            end
            riscv_pkg::op_jal: begin
                dec_d.imm     = imm_j;
                dec_d.alu_op  = riscv_pkg::alu_add;
                dec_d.src_sel = riscv_pkg::src_pc_imm;
                dec_d.rd_wen  = 1'b1;
                dec_d.jal     = 1'b1;
            end
            riscv_pkg::op_jalr: begin
                dec_d.imm     = imm_i;
                dec_d.alu_op  = riscv_pkg::alu_add;
                dec_d.src_sel = riscv_pkg::src_rs1_imm;
                dec_d.rd_wen  = 1'b1;
                dec_d.jalr    = 1'b1;
            end
            riscv_pkg::op_branch: begin
                // alu forms the target, compare uses the raw registers
                dec_d.imm     = imm_b;
                dec_d.alu_op  = riscv_pkg::alu_add;
                dec_d.src_sel = riscv_pkg::src_pc_imm;
                case (funct3)
                    3'b000:  dec_d.br_op = riscv_pkg::br_eq;
                    3'b001:  dec_d.br_op = riscv_pkg::br_ne;
                    3'b100:  dec_d.br_op = riscv_pkg::br_lt;
                    3'b101:  dec_d.br_op = riscv_pkg::br_ge;
                    default: dec_d.br_op = riscv_pkg::br_none;
                endcase
            end
            riscv_pkg::op_load: begin
                dec_d.imm     = imm_i;
                dec_d.alu_op  = riscv_pkg::alu_add;
                dec_d.src_sel = riscv_pkg::src_rs1_imm;
                dec_d.mem_op  = riscv_pkg::mem_load;
                dec_d.rd_wen  = 1'b1;
            end
            riscv_pkg::op_store: begin
                dec_d.imm     = imm_s;
                dec_d.alu_op  = riscv_pkg::alu_add;
                dec_d.src_sel = riscv_pkg::src_rs1_imm;
                dec_d.mem_op  = riscv_pkg::mem_store;
            end
            riscv_pkg::op_imm: begin
                dec_d.imm     = imm_i;
                dec_d.alu_op  = func_op;
                dec_d.src_sel = riscv_pkg::src_rs1_imm;
                dec_d.rd_wen  = 1'b1;
            end
            riscv_pkg::op_reg: begin
                dec_d.alu_op  = func_op;
                dec_d.rd_wen  = 1'b1;
            end
            riscv_pkg::op_sys: begin
                // only ecall is recognised
                dec_d.halt    = (instr[31:7] == '0);
            end
            default: begin
                dec_d.rd_wen  = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= fetch_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            dec_pkt <= dec_d;
        end
    end

endmodule

//--- riscv_regfile.sv
`timescale 1ns/1ps

module riscv_regfile (
    input  logic                 clk,
    input  logic                 rst_n,
    input  riscv_pkg::reg_addr_t rs1_addr,
    output riscv_pkg::word_t     rs1_data,
    input  riscv_pkg::reg_addr_t rs2_addr,
    output riscv_pkg::word_t     rs2_data,
    input  logic                 rd_wen,
    input  riscv_pkg::reg_addr_t rd_addr,
    input  riscv_pkg::word_t     rd_data
);

    riscv_pkg::word_t regs [2**riscv_pkg::reg_aw];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**riscv_pkg::reg_aw; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_wen && rd_addr != '0) begin
            regs[rd_addr] <= rd_data;
        end
    end

    // x0 is hardwired
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

//--- riscv_exu.sv
`timescale 1ns/1ps

module riscv_exu (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                dec_valid,
    input  riscv_pkg::dec_pkt_t dec_pkt,
    input  riscv_pkg::word_t    rs1_data,
    input  riscv_pkg::word_t    rs2_data,
    output logic                exe_valid,
    output riscv_pkg::exe_pkt_t exe_pkt
);

    riscv_pkg::word_t op_a;
    riscv_pkg::word_t op_b;
    riscv_pkg::word_t alu_out;
    riscv_pkg::word_t seq_pc;
    logic             taken;

    always_comb begin
        case (dec_pkt.src_sel)
            riscv_pkg::src_rs1_imm:  {op_a, op_b} = {rs1_data, dec_pkt.imm};
            riscv_pkg::src_pc_imm:   {op_a, op_b} = {dec_pkt.pc, dec_pkt.imm};
            riscv_pkg::src_zero_imm: {op_a, op_b} = {riscv_pkg::word_t'(0), dec_pkt.imm};
            default:                 {op_a, op_b} = {rs1_data, rs2_data};
        endcase
    end

    always_comb begin
        case (dec_pkt.alu_op)
            riscv_pkg::alu_add:  alu_out = op_a + op_b;
            riscv_pkg::alu_sub:  alu_out = op_a - op_b;
            riscv_pkg::alu_and:  alu_out = op_a & op_b;
            riscv_pkg::alu_or:   alu_out = op_a | op_b;
            riscv_pkg::alu_xor:  alu_out = op_a ^ op_b;
            riscv_pkg::alu_sll:  alu_out = op_a << op_b[4:0];
            riscv_pkg::alu_srl:  alu_out = op_a >> op_b[4:0];
            riscv_pkg::alu_sra:  alu_out = $signed(op_a) >>> op_b[4:0];
            riscv_pkg::alu_slt:  alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            riscv_pkg::alu_sltu: alu_out = {31'b0, op_a < op_b};
            default:             alu_out = op_b;
        endcase
    end

    // branch compare on the register values, target comes from the alu
    always_comb begin
        case (dec_pkt.br_op)
            riscv_pkg::br_eq: taken = (rs1_data == rs2_data);
            riscv_pkg::br_ne: taken = (rs1_data != rs2_data);
            riscv_pkg::br_lt: taken = ($signed(rs1_data) < $signed(rs2_data));
            riscv_pkg::br_ge: taken = ($signed(rs1_data) >= $signed(rs2_data));
            default:          taken = 1'b0;
        endcase
    end

    assign seq_pc = dec_pkt.pc + 32'd4;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exe_valid <= 1'b0;
        end else begin
            exe_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            exe_pkt.pc         <= dec_pkt.pc;
            exe_pkt.result     <= (dec_pkt.jal || dec_pkt.jalr) ? seq_pc : alu_out;
            exe_pkt.store_data <= rs2_data;
            if (dec_pkt.jal || taken) begin
                exe_pkt.next_pc <= alu_out;
            end else if (dec_pkt.jalr) begin
                exe_pkt.next_pc <= {alu_out[31:1], 1'b0};
            end else begin
                exe_pkt.next_pc <= seq_pc;
            end
            exe_pkt.rd     <= dec_pkt.rd;
            exe_pkt.rd_wen <= dec_pkt.rd_wen;
            exe_pkt.link   <= dec_pkt.jal | dec_pkt.jalr;
            exe_pkt.mem_op <= dec_pkt.mem_op;
            exe_pkt.halt   <= dec_pkt.halt;
        end
    end

endmodule

//--- riscv_lsu.sv
`timescale 1ns/1ps

module riscv_lsu (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 exe_valid,
    input  riscv_pkg::exe_pkt_t  exe_pkt,
    output riscv_pkg::apb_req_t  apb_req,
    input  riscv_pkg::apb_rsp_t  apb_rsp,
    output logic                 rd_wen,
    output riscv_pkg::reg_addr_t rd_addr,
    output riscv_pkg::word_t     rd_data,
    output logic                 retire,
    output riscv_pkg::word_t     next_pc,
    output logic                 halted
);

    typedef enum logic [1:0] {
        st_idle,
        st_setup,
        st_access
    } state_t;

    state_t              state;
    riscv_pkg::exe_pkt_t exe_q;
    riscv_pkg::exe_pkt_t cur;
    logic                is_mem;

    assign is_mem = (exe_pkt.mem_op != riscv_pkg::mem_none);

    // idle works on the incoming packet, the apb phases on the held copy
    assign cur = (state == st_idle) ? exe_pkt : exe_q;

    always_ff @(posedge clk) begin
        if (exe_valid) begin
            exe_q <= exe_pkt;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= st_idle;
            halted <= 1'b0;
        end else begin
            case (state)
                st_idle:   if (exe_valid && is_mem) state <= st_setup;
                st_setup:  state <= st_access;
                st_access: if (apb_rsp.pready) state <= st_idle;
                default:   state <= st_idle;
            endcase
            // sticky until reset
            if (retire && cur.halt) begin
                halted <= 1'b1;
            end
        end
    end

    assign apb_req.paddr   = exe_q.result;
    assign apb_req.psel    = (state != st_idle);
    assign apb_req.penable = (state == st_access);
    assign apb_req.pwrite  = (exe_q.mem_op == riscv_pkg::mem_store);
    assign apb_req.pwdata  = exe_q.store_data;

    assign retire = (state == st_idle && exe_valid && !is_mem)
                  | (state == st_access && apb_rsp.pready);

    // writeback
    assign rd_wen  = retire & cur.rd_wen;
    assign rd_addr = cur.rd;
    assign rd_data = (cur.mem_op == riscv_pkg::mem_load) ? apb_rsp.prdata : cur.result;
    assign next_pc = cur.next_pc;

endmodule

//--- riscv_top.sv
`timescale 1ns/1ps

module riscv_top (
    input  logic                clk,
    input  logic                rst_n,
    output logic                imem_req,
    output riscv_pkg::word_t    imem_addr,
    input  riscv_pkg::word_t    imem_data,
    output riscv_pkg::apb_req_t apb_req,
    input  riscv_pkg::apb_rsp_t apb_rsp,
    output logic                halted
);

    // fetch
    logic                  fetch_valid;
    riscv_pkg::fetch_pkt_t fetch_pkt;

    // decode
    logic                  dec_valid;
    riscv_pkg::dec_pkt_t   dec_pkt;

    // register file reads
    riscv_pkg::word_t      rs1_data;
    riscv_pkg::word_t      rs2_data;

    // execute
    logic                  exe_valid;
    riscv_pkg::exe_pkt_t   exe_pkt;

    // writeback and retire
    logic                  rd_wen;
    riscv_pkg::reg_addr_t  rd_addr;
    riscv_pkg::word_t      rd_data;
    logic                  retire;
    riscv_pkg::word_t      next_pc;

    riscv_ifu riscv_ifu_u0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .retire      (retire),
        .next_pc     (next_pc),
        .halted      (halted),
        .imem_req    (imem_req),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .fetch_valid (fetch_valid),
        .fetch_pkt   (fetch_pkt)
    );

    riscv_idu riscv_idu_u0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_valid (fetch_valid),
        .fetch_pkt   (fetch_pkt),
        .dec_valid   (dec_valid),
        .dec_pkt     (dec_pkt)
    );

    riscv_regfile riscv_regfile_u0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (dec_pkt.rs1),
        .rs1_data (rs1_data),
        .rs2_addr (dec_pkt.rs2),
        .rs2_data (rs2_data),
        .rd_wen   (rd_wen),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    riscv_exu riscv_exu_u0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .dec_valid (dec_valid),
        .dec_pkt   (dec_pkt),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .exe_valid (exe_valid),
        .exe_pkt   (exe_pkt)
    );

    riscv_lsu riscv_lsu_u0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .exe_valid (exe_valid),
        .exe_pkt   (exe_pkt),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .rd_wen    (rd_wen),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .retire    (retire),
        .next_pc   (next_pc),
        .halted    (halted)
    );

endmodule

//--- tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
    output logic clk,
    output logic rst_n
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // reset held low for the first 8 cycles
    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

//--- riscv_chk.sv
`timescale 1ns/1ps

module riscv_chk (
    input logic                clk,
    input logic                rst_n,
    input riscv_pkg::apb_req_t apb_req,
    input riscv_pkg::apb_rsp_t apb_rsp,
    input logic                imem_req,
    input logic                halted
);

    // assertion failures so far
    int fail_count = 0;

    // access phase only after a setup cycle
    penable_after_setup: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(apb_req.penable) |-> $past(apb_req.psel && !apb_req.penable))
        else begin
            fail_count++;
            $error("penable rose without a setup cycle");
        end

    // request held while the slave stalls
    apb_stable_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
        (apb_req.psel && apb_req.penable && !apb_rsp.pready) |=>
        (apb_req.psel && apb_req.penable && $stable(apb_req.paddr) &&
         $stable(apb_req.pwrite) && $stable(apb_req.pwdata)))
        else begin
            fail_count++;
            $error("APB request changed during a wait state");
        end

    // halt is final, no fetch ever follows it
    halt_is_final: assert property (@(posedge clk) disable iff (!rst_n)
        halted |=> (halted && !imem_req))
        else begin
            fail_count++;
            $error("instruction fetch issued or halt dropped after the core halted");
        end

endmodule

bind riscv_top riscv_chk chk_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .apb_req  (apb_req),
    .apb_rsp  (apb_rsp),
    .imem_req (imem_req),
    .halted   (halted)
);

//--- tb_riscv_top.sv
`timescale 1ns/1ps

module tb_riscv_top;

    localparam int test_count = 5;
    localparam int test_cycles = 400;
    localparam int halt_limit = 350;

    logic                clk;
    logic                gen_rst_n;
    logic                test_rst_n;
    logic                rst_n;
    logic                imem_req;
    riscv_pkg::word_t    imem_addr;
    riscv_pkg::word_t    imem_data;
    riscv_pkg::apb_req_t apb_req;
    riscv_pkg::apb_rsp_t apb_rsp;
    logic                halted;

    riscv_pkg::word_t imem [256];
    riscv_pkg::word_t dmem [riscv_pkg::word_t];
    riscv_pkg::word_t prog [$];
    riscv_pkg::word_t seen_addr [$];
    riscv_pkg::word_t seen_data [$];
    riscv_pkg::word_t exp_addr [$];
    riscv_pkg::word_t exp_data [$];

    int store_errors;
    int halt_errors;
    int protocol_errors;

    // slave side state
    riscv_pkg::apb_req_t req_s;
    logic                rdy_s;
    logic                req_v;
    riscv_pkg::word_t    addr_v;
    int                  waits;

    tb_clkgen clkgen_i (
        .clk   (clk),
        .rst_n (gen_rst_n)
    );

    assign rst_n = gen_rst_n & test_rst_n;

    riscv_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .imem_req  (imem_req),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .halted    (halted)
    );

    // instruction memory, one cycle of read latency
    always @(posedge clk) begin
        req_v  = imem_req;
        addr_v = imem_addr;
        #1;
        if (req_v) begin
            imem_data = imem[addr_v[9:2]];
        end
    end

    function automatic riscv_pkg::word_t dmem_read(riscv_pkg::word_t addr);
        if (dmem.exists(addr)) begin
            return dmem[addr];
        end
        return '0;
    endfunction

    // APB slave with 0 to 3 random wait states
    always @(posedge clk) begin
        req_s = apb_req;
        rdy_s = apb_rsp.pready;
        if (!rst_n) begin
            #1 apb_rsp = '0;
        end else if (req_s.psel && req_s.penable && rdy_s) begin
            if (halted) begin
                halt_errors++;
                $display("APB transfer completed after the core halted at %0t", $time);
            end
            if (req_s.pwrite) begin
                seen_addr.push_back(req_s.paddr);
                seen_data.push_back(req_s.pwdata);
                dmem[req_s.paddr] = req_s.pwdata;
            end
            #1 apb_rsp.pready = 1'b0;
        end else if (req_s.psel) begin
            if (!req_s.penable) begin
                waits = $urandom % 4;
            end else begin
                waits--;
            end
            #1;
            apb_rsp.pready = (waits == 0);
            apb_rsp.prdata = dmem_read(req_s.paddr);
        end
    end

    function automatic riscv_pkg::word_t enc_r(logic [6:0] f7, logic [4:0] rs2,
                                               logic [4:0] rs1, logic [2:0] f3,
                                               logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, riscv_pkg::op_reg};
    endfunction

    function automatic riscv_pkg::word_t enc_i(logic [31:0] imm, logic [4:0] rs1,
                                               logic [2:0] f3, logic [4:0] rd,
                                               logic [6:0] op);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    function automatic riscv_pkg::word_t enc_s(logic [31:0] imm, logic [4:0] rs2,
                                               logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], riscv_pkg::op_store};
    endfunction

    function automatic riscv_pkg::word_t enc_b(logic [31:0] imm, logic [4:0] rs2,
                                               logic [4:0] rs1, logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], riscv_pkg::op_branch};
    endfunction

    function automatic riscv_pkg::word_t enc_j(logic [31:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, riscv_pkg::op_jal};
    endfunction

    function automatic riscv_pkg::word_t pc_now();
        return riscv_pkg::word_t'(prog.size() * 4);
    endfunction

    task automatic expect_store(riscv_pkg::word_t addr, riscv_pkg::word_t data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic load_const(logic [4:0] rd, riscv_pkg::word_t value);
        riscv_pkg::word_t hi;
        hi = (value + 32'h800) >> 12;
        prog.push_back({hi[19:0], rd, riscv_pkg::op_lui});
        prog.push_back(enc_i(value, rd, 3'b000, rd, riscv_pkg::op_imm));
    endtask

    task automatic check_store(riscv_pkg::word_t got_addr, riscv_pkg::word_t got_data,
                               riscv_pkg::word_t want_addr, riscv_pkg::word_t want_data);
        if (got_addr !== want_addr || got_data !== want_data) begin
            store_errors++;
            $display("ERROR %0t: store to %h data %h, expected %h data %h",
                     $time, got_addr, got_data, want_addr, want_data);
        end
    endtask

    task automatic check_halt();
        if (halted !== 1'b1) begin
            halt_errors++;
            $display("ERROR %0t: halted is low after the program ended", $time);
        end
        repeat (20) begin
            @(negedge clk);
            if (imem_req || apb_req.psel) begin
                halt_errors++;
                $display("ERROR %0t: fetch or APB request after halt", $time);
            end
        end
    endtask

    // loads prog, resets the core, runs to halt and compares stores
    task automatic run_program(string name);
        int cycles;
        prog.push_back(32'h0000_0073);
        @(posedge clk);
        #1 test_rst_n = 1'b0;
        foreach (imem[i]) imem[i] = 32'h0000_0073;
        foreach (prog[i]) imem[i] = prog[i];
        dmem.delete();
        seen_addr.delete();
        seen_data.delete();
        repeat (2) @(posedge clk);
        #1 test_rst_n = 1'b1;
        cycles = 0;
        while (!halted && cycles < halt_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            halt_errors++;
            $display("%s: core did not halt within %0d cycles", name, halt_limit);
        end
        check_halt();
        if (seen_addr.size() != exp_addr.size()) begin
            store_errors++;
            $display("ERROR %0t: %s saw %0d stores, expected %0d",
                     $time, name, seen_addr.size(), exp_addr.size());
        end else begin
            foreach (exp_addr[i]) begin
                check_store(seen_addr[i], seen_data[i], exp_addr[i], exp_data[i]);
            end
        end
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic alu_case(logic [2:0] f3, logic [6:0] f7, int off, riscv_pkg::word_t want);
        prog.push_back(enc_r(f7, 5'd2, 5'd1, f3, 5'd3));
        prog.push_back(enc_s(off, 5'd3, 5'd10));
        expect_store(32'h100 + off, want);
    endtask

    task automatic test_alu();
        riscv_pkg::word_t a;
        riscv_pkg::word_t b;
        a = -20;
        b = 7;
        prog.push_back(enc_i(a, 5'd0, 3'b000, 5'd1, riscv_pkg::op_imm));
        prog.push_back(enc_i(b, 5'd0, 3'b000, 5'd2, riscv_pkg::op_imm));
        prog.push_back(enc_i(32'h100, 5'd0, 3'b000, 5'd10, riscv_pkg::op_imm));
        // results worked out by hand for -20 and 7
        alu_case(3'b000, 7'h00, 0, 32'hffff_fff3);
        alu_case(3'b000, 7'h20, 4, 32'hffff_ffe5);
        alu_case(3'b111, 7'h00, 8, 32'h0000_0004);
        alu_case(3'b110, 7'h00, 12, 32'hffff_ffef);
        alu_case(3'b100, 7'h00, 16, 32'hffff_ffeb);
        alu_case(3'b001, 7'h00, 20, 32'hffff_f600);
        alu_case(3'b101, 7'h00, 24, 32'h01ff_ffff);
        alu_case(3'b101, 7'h20, 28, 32'hffff_ffff);
        alu_case(3'b010, 7'h00, 32, 32'h0000_0001);
        alu_case(3'b011, 7'h00, 36, 32'h0000_0000);
        // addi with a negative immediate
        prog.push_back(enc_i(-100, 5'd2, 3'b000, 5'd3, riscv_pkg::op_imm));
        prog.push_back(enc_s(40, 5'd3, 5'd10));
        expect_store(32'h128, b - 100);
        run_program("alu");
    endtask

    task automatic test_upper();
        riscv_pkg::word_t pc;
        prog.push_back({20'h12345, 5'd5, riscv_pkg::op_lui});
        prog.push_back(enc_s(32'h200, 5'd5, 5'd0));
        expect_store(32'h200, 32'h1234_5000);
        pc = pc_now();
        prog.push_back({20'h00001, 5'd6, riscv_pkg::op_auipc});
        prog.push_back(enc_s(32'h204, 5'd6, 5'd0));
        expect_store(32'h204, pc + 32'h1000);
        prog.push_back(enc_i(55, 5'd0, 3'b000, 5'd0, riscv_pkg::op_imm));
        prog.push_back(enc_r(7'h00, 5'd6, 5'd5, 3'b000, 5'd0));
        prog.push_back(enc_s(32'h208, 5'd0, 5'd0));
        expect_store(32'h208, 32'h0);
        run_program("upper");
    endtask

    // a branch over a store that must never happen
    task automatic branch_case(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                               logic taken, int off);
        prog.push_back(enc_b(8, rs2, rs1, f3));
        prog.push_back(enc_s(taken ? 64 : off, 5'd4, 5'd10));
        if (!taken) begin
            expect_store(32'h300 + off, 32'd1);
        end
    endtask

    task automatic test_control();
        riscv_pkg::word_t pc;
        prog.push_back(enc_i(5, 5'd0, 3'b000, 5'd1, riscv_pkg::op_imm));
        prog.push_back(enc_i(5, 5'd0, 3'b000, 5'd2, riscv_pkg::op_imm));
        prog.push_back(enc_i(-3, 5'd0, 3'b000, 5'd3, riscv_pkg::op_imm));
        prog.push_back(enc_i(1, 5'd0, 3'b000, 5'd4, riscv_pkg::op_imm));
        prog.push_back(enc_i(32'h300, 5'd0, 3'b000, 5'd10, riscv_pkg::op_imm));
        branch_case(3'b000, 5'd1, 5'd2, 1'b1, 0);
        branch_case(3'b000, 5'd1, 5'd3, 1'b0, 0);
        branch_case(3'b001, 5'd1, 5'd3, 1'b1, 4);
        branch_case(3'b001, 5'd1, 5'd2, 1'b0, 4);
        branch_case(3'b100, 5'd3, 5'd1, 1'b1, 8);
        branch_case(3'b100, 5'd1, 5'd3, 1'b0, 8);
        branch_case(3'b101, 5'd1, 5'd2, 1'b1, 12);
        branch_case(3'b101, 5'd3, 5'd1, 1'b0, 12);
        pc = pc_now();
        prog.push_back(enc_j(8, 5'd5));
        prog.push_back(enc_s(64, 5'd4, 5'd10));
        prog.push_back(enc_s(16, 5'd5, 5'd10));
        expect_store(32'h310, pc + 4);
        // odd offset, bit 0 of the target is dropped
        pc = pc_now();
        prog.push_back({20'h0, 5'd6, riscv_pkg::op_auipc});
        prog.push_back(enc_i(13, 5'd6, 3'b000, 5'd7, riscv_pkg::op_jalr));
        prog.push_back(enc_s(64, 5'd4, 5'd10));
        prog.push_back(enc_s(20, 5'd7, 5'd10));
        expect_store(32'h314, pc + 8);
        run_program("control");
    endtask

    task automatic test_memory();
        riscv_pkg::word_t v;
        prog.push_back(enc_i(32'h400, 5'd0, 3'b000, 5'd10, riscv_pkg::op_imm));
        for (int k = 0; k < 6; k++) begin
            v = $urandom;
            load_const(5'd1, v);
            prog.push_back(enc_s(k * 8, 5'd1, 5'd10));
            prog.push_back(enc_i(k * 8, 5'd10, 3'b010, 5'd2, riscv_pkg::op_load));
            prog.push_back(enc_s(128 + k * 4, 5'd2, 5'd10));
            expect_store(32'h400 + k * 8, v);
            expect_store(32'h480 + k * 4, v);
        end
        run_program("memory");
    endtask

    task automatic test_halt();
        prog.push_back(enc_i(9, 5'd0, 3'b000, 5'd1, riscv_pkg::op_imm));
        prog.push_back(enc_s(32'h40, 5'd1, 5'd0));
        expect_store(32'h40, 32'd9);
        prog.push_back(32'h0000_0073);
        // must never execute
        prog.push_back(enc_s(32'h44, 5'd1, 5'd0));
        run_program("halt");
    endtask

    initial begin
        imem_data       = '0;
        apb_rsp         = '0;
        test_rst_n      = 1'b1;
        store_errors    = 0;
        halt_errors     = 0;
        protocol_errors = 0;
        void'($urandom(32'h2464));
        wait (gen_rst_n === 1'b1);
        test_alu();
        test_upper();
        test_control();
        test_memory();
        test_halt();
        protocol_errors = dut_i.chk_i.fail_count;
        $display("errors: store %0d halt %0d protocol %0d",
                 store_errors, halt_errors, protocol_errors);
        if (store_errors + halt_errors + protocol_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(test_count * test_cycles * 8);
        $display("run stopped by the watchdog, the tests did not finish in time");
        $display("TEST FAIL");
        $finish;
    end

endmodule

//--- sources.f
riscv_pkg.sv
riscv_ifu.sv
riscv_idu.sv
riscv_regfile.sv
riscv_exu.sv
riscv_lsu.sv
riscv_top.sv
tb_clkgen.sv
riscv_chk.sv
tb_riscv_top.sv

//--- Bender.yml
package:
  name: riscv_core

sources:
  - files:
      - riscv_pkg.sv
      - riscv_ifu.sv
      - riscv_idu.sv
      - riscv_regfile.sv
      - riscv_exu.sv
      - riscv_lsu.sv
      - riscv_top.sv
  - target: test
    files:
      - tb_clkgen.sv
      - riscv_chk.sv
      - tb_riscv_top.sv
